// File: filelist.f
hdl/rtr_topo_pkg.sv
hdl/rtr_flit_pkg.sv
hdl/rtr_flit_buffer.sv
hdl/rtr_credit_counter.sv
hdl/rtr_route_compute_desc.sv
hdl/rtr_route_filter_desc.sv
hdl/rtr_input_ctrl.sv
hdl/rtr_input_port.sv
dv/rtr_input_port_assertions.sv
dv/tb_rtr_input_port.sv

// File: Makefile
# Verilator build and run for the router input port testbench

SIM      := verilator
TOP      := tb_rtr_input_port
RTL_TOP  := rtr_input_port
FILELIST := filelist.f
FLAGS    := --binary --timing --assert
LINT     := --lint-only --timing
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "testbench reported failure" && exit 1)

lint:
	$(SIM) $(LINT) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_rtr_input_port.sv
// testbench for the router input port: directed routing, discard and back-pressure tests
module tb_rtr_input_port;
   import rtr_topo_pkg::*;
   import rtr_flit_pkg::*;

   localparam int wait_limit = 200;

   logic clk, rst, in_valid, credit_out, out_valid, out_rc, credit_in, err_port, err_class;
   logic [coord_w-1:0] my_x, my_y;
   flit_t in_flit, out_flit;
   port_vec_t out_port;
   logic hold_credits;
   logic [1:0] ret_pipe;
   logic [15:0] lfsr_state;
   int errors, checks, up_credits, owed, pending_ret;
   int credit_pulses, err_port_pulses, err_class_pulses, base_credit, base_err_p, base_err_c;
   flit_t got_flit[$];
   port_vec_t got_port[$];
   logic got_rc[$];
   flit_t sent[$];

   rtr_input_port #(.port_id(port_xp)) u_rtr_input_port (
      .clk (clk), .rst (rst), .my_x (my_x), .my_y (my_y), .in_valid (in_valid),
      .in_flit (in_flit), .credit_out (credit_out), .out_valid (out_valid),
      .out_flit (out_flit), .out_port (out_port), .out_rc (out_rc),
      .credit_in (credit_in), .err_port (err_port), .err_class (err_class)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // --------------------
   // link models and output monitor
   // downstream returns each credit two cycles after the flit, unless held back
   always @(posedge clk) begin
      if (rst) begin
         up_credits <= in_buf_depth;
         ret_pipe <= '0;
         owed <= 0;
         credit_in <= 1'b0;
         credit_pulses <= 0;
         err_port_pulses <= 0;
         err_class_pulses <= 0;
      end else begin
         up_credits <= up_credits - (in_valid ? 1 : 0) + (credit_out ? 1 : 0);
         ret_pipe <= {ret_pipe[0], out_valid};
         pending_ret = owed + (ret_pipe[1] ? 1 : 0);
         if (!hold_credits && pending_ret > 0) begin
            credit_in <= 1'b1;
            pending_ret = pending_ret - 1;
         end else begin
            credit_in <= 1'b0;
         end
         owed <= pending_ret;
         credit_pulses <= credit_pulses + (credit_out ? 1 : 0);
         err_port_pulses <= err_port_pulses + (err_port ? 1 : 0);
         err_class_pulses <= err_class_pulses + (err_class ? 1 : 0);
         if (out_valid) begin
            got_flit.push_back(out_flit);
            got_port.push_back(out_port);
            got_rc.push_back(out_rc);
         end
      end
   end

   // 16-bit Fibonacci LFSR with taps 16 14 13 11 and one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic flit_t make_head(input flit_kind_t k, input logic rc,
                                       input int dx, input int dy, input int ix, input int iy);
      flit_t f;
      f.head.kind = k;
      f.head.rc = rc;
      f.head.dest_x = coord_w'(dx);
      f.head.dest_y = coord_w'(dy);
      f.head.int_x = coord_w'(ix);
      f.head.int_y = coord_w'(iy);
      f.head.tag = 17'(rand_bits(17));
      return f;
   endfunction

   function automatic flit_t make_body(input flit_kind_t k);
      flit_t f;
      f.body.kind = k;
      f.body.payload = 30'(rand_bits(30));
      return f;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // --------------------
   // stimulus helpers
   task automatic send_flit(input flit_t f);
      int waited;
      waited = 0;
      @(posedge clk);
      while (up_credits <= (in_valid ? 1 : 0) && waited <= wait_limit) begin
         in_valid <= 1'b0;
         waited++;
         @(posedge clk);
      end
      if (waited > wait_limit) begin
         $display("timeout at %0t: upstream never got a credit back", $time);
         errors++;
      end
      in_valid <= 1'b1;
      in_flit <= f;
      sent.push_back(f);
   endtask

   task automatic stop_input();
      @(posedge clk);
      in_valid <= 1'b0;
   endtask

   task automatic wait_outputs(input int n);
      int waited;
      waited = 0;
      while (got_flit.size() < n && waited <= wait_limit) begin
         @(negedge clk);
         waited++;
      end
      if (waited > wait_limit) begin
         $display("timeout at %0t: only %0d of %0d flits left the port", $time,
                  got_flit.size(), n);
         errors++;
      end
   endtask

   task automatic wait_credits(input int n);
      int waited;
      waited = 0;
      while (credit_pulses - base_credit < n && waited <= wait_limit) begin
         @(posedge clk);
         waited++;
      end
      if (waited > wait_limit) begin
         $display("timeout at %0t: upstream credits were not returned", $time);
         errors++;
      end
   endtask

   // wait until the port is idle and all credits are home, then clear the record
   task automatic settle();
      int waited;
      waited = 0;
      while ((owed != 0 || ret_pipe != 2'b00 || !u_rtr_input_port.route_valid)
             && waited <= wait_limit) begin
         @(posedge clk);
         waited++;
      end
      if (waited > wait_limit) begin
         $display("timeout at %0t: port did not return to idle", $time);
         errors++;
      end
      repeat (3) @(posedge clk);
      got_flit.delete();
      got_port.delete();
      got_rc.delete();
      sent.delete();
      base_credit = credit_pulses;
      base_err_p = err_port_pulses;
      base_err_c = err_class_pulses;
   endtask

   task automatic check_flits(input int first, input int n, input int exp_port, input logic exp_rc);
      for (int i = first; i < first + n; i++) begin
         if (i >= got_flit.size()) begin
            $display("flit %0d never left the port", i);
            errors++;
         end else begin
            check_value("out_flit", 32'(got_flit[i]), 32'(sent[i]));
            check_value("out_port", 32'(got_port[i]), 32'(1 << exp_port));
            check_value("out_rc", 32'(got_rc[i]), 32'(exp_rc));
         end
      end
   endtask

   task automatic check_flags(input int exp_err_p, input int exp_credits);
      check_value("err_port pulses", 32'(err_port_pulses - base_err_p), 32'(exp_err_p));
      check_value("err_class pulses", 32'(err_class_pulses - base_err_c), 32'd0);
      check_value("credit_out pulses", 32'(credit_pulses - base_credit), 32'(exp_credits));
   endtask

   // --------------------
   // directed tests
   task automatic single_flit(input logic rc, input int dx, input int dy, input int ix,
                              input int iy, input int exp_port, input logic exp_rc);
      settle();
      send_flit(make_head(fk_head_tail, rc, dx, dy, ix, iy));
      stop_input();
      wait_outputs(1);
      repeat (3) @(posedge clk);
      check_flits(0, 1, exp_port, exp_rc);
      check_flags(0, 1);
   endtask

   task automatic discard_packet(input int dx, input int dy, input int n);
      settle();
      send_flit(make_head(n == 1 ? fk_head_tail : fk_head, 1'b1, dx, dy, 3, 3));
      for (int i = 1; i < n; i++) begin
         send_flit(make_body(i == n - 1 ? fk_tail : fk_body));
      end
      stop_input();
      wait_credits(n);
      repeat (5) @(posedge clk);
      check_value("flits out", 32'(got_flit.size()), 32'd0);
      check_flags(1, n);
   endtask

   task automatic two_packets();
      settle();
      send_flit(make_head(fk_head, 1'b1, 1, 3, 0, 0));
      repeat (3) send_flit(make_body(fk_body));
      send_flit(make_body(fk_tail));
      // second packet still in phase 0 and heading for (3,6)
      send_flit(make_head(fk_head, 1'b0, 0, 0, 3, 6));
      send_flit(make_body(fk_tail));
      stop_input();
      wait_outputs(7);
      check_flits(0, 5, port_xm, 1'b1);
      check_flits(5, 2, port_yp, 1'b0);
      check_flags(0, 7);
   endtask

   task automatic back_pressure();
      settle();
      hold_credits <= 1'b1;
      send_flit(make_head(fk_head, 1'b1, 0, 3, 0, 0));
      repeat (4) send_flit(make_body(fk_body));
      send_flit(make_body(fk_tail));
      stop_input();
      wait_outputs(out_credits);
      repeat (10) @(posedge clk);
      check_value("flits out while stalled", 32'(got_flit.size()), 32'(out_credits));
      hold_credits <= 1'b0;
      wait_outputs(6);
      check_flits(0, 6, port_xm, 1'b1);
      check_flags(0, 6);
   endtask

   initial begin
      credit_in <= 1'b0;
      rst = 1'b1;
      in_valid = 1'b0;
      in_flit = '0;
      my_x = 3'd3;
      my_y = 3'd3;
      hold_credits = 1'b0;
      lfsr_state = 16'd42;
      errors = 0;
      checks = 0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      // class 1 arriving on x-plus may only go x-minus or eject
      single_flit(1'b1, 1, 3, 0, 0, port_xm, 1'b1);
      single_flit(1'b1, 3, 3, 0, 0, port_local, 1'b1);
      single_flit(1'b0, 0, 0, 3, 5, port_yp, 1'b0);
      single_flit(1'b0, 0, 0, 5, 3, port_xp, 1'b0);
      // phase advance at the intermediate node
      single_flit(1'b0, 3, 5, 3, 3, port_yp, 1'b1);
      single_flit(1'b0, 1, 3, 3, 3, port_xm, 1'b1);
      single_flit(1'b0, 3, 6, 3, 1, port_ym, 1'b0);
      discard_packet(3, 0, 3);
      discard_packet(5, 3, 1);
      two_packets();
      back_pressure();
      repeat (5) @(posedge clk);
      errors += u_rtr_input_port.u_assertions.fail_count;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: dv/rtr_input_port_assertions.sv
// concurrent checks on the input port: credits, error pulse timing, upstream overflow
module rtr_input_port_assertions (
   input logic  clk,
   input logic  rst,
   input logic  in_valid,
   input logic  credit_out,
   input logic  out_valid,
   input logic  credit_in,
   input logic  err_port,
   input logic  err_class,
   input logic  route_valid
);
   import rtr_topo_pkg::*;

   // buffer occupancy as seen from the link
   logic [3:0] occ;
   // downstream credits as seen from the link
   logic [3:0] dn_credits;
   int         fail_count = 0;

   always_ff @(posedge clk) begin
      if (rst) begin
         occ <= '0;
      end else if (in_valid && !credit_out) begin
         occ <= occ + 4'd1;
      end else if (!in_valid && credit_out) begin
         occ <= occ - 4'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dn_credits <= 4'(out_credits);
      end else if (out_valid && !credit_in) begin
         dn_credits <= dn_credits - 4'd1;
      end else if (!out_valid && credit_in) begin
         dn_credits <= dn_credits + 4'd1;
      end
   end

   a_out_needs_credit: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> (dn_credits != '0))
      else begin
         $error("flit sent with no downstream credit");
         fail_count++;
      end

   a_err_after_route: assert property (@(posedge clk) disable iff (rst)
      (err_port || err_class) |-> ($past(route_valid) && !route_valid))
      else begin
         $error("error flag outside the route cycle");
         fail_count++;
      end

   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      !((occ == 4'(in_buf_depth)) && in_valid && !credit_out))
      else begin
         $error("upstream wrote into a full buffer");
         fail_count++;
      end

endmodule

bind rtr_input_port rtr_input_port_assertions u_assertions (
   .clk (clk), .rst (rst), .in_valid (in_valid), .credit_out (credit_out),
   .out_valid (out_valid), .credit_in (credit_in), .err_port (err_port),
   .err_class (err_class), .route_valid (route_valid)
);

// File: hdl/rtr_input_port.sv
// router input port: flit buffer, route compute and filter, controller and credit counter
module rtr_input_port #(
   parameter int port_id = rtr_topo_pkg::port_xp
) (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [rtr_topo_pkg::coord_w-1:0]   my_x,
   input  logic [rtr_topo_pkg::coord_w-1:0]   my_y,
   input  logic                               in_valid,
   input  rtr_flit_pkg::flit_t                in_flit,
   output logic                               credit_out,
   output logic                               out_valid,
   output rtr_flit_pkg::flit_t                out_flit,
   output rtr_topo_pkg::port_vec_t            out_port,
   output logic                               out_rc,
   input  logic                               credit_in,
   output logic                               err_port,
   output logic                               err_class
);
   import rtr_topo_pkg::*;
   import rtr_flit_pkg::*;

   flit_t       buf_flit;
   logic        buf_valid;
   flit_kind_t  head_kind;
   logic        cur_rc;
   port_vec_t   route_op;
   logic        route_rc;
   port_vec_t   filt_op;
   logic        filt_rc;
   logic        filt_err_port;
   logic        filt_err_class;
   logic        route_valid;
   logic        pop;
   logic        consume;
   logic        has_credit;

   // routing fields are read through the head view of the buffer output
   assign head_kind = buf_flit.head.kind;
   assign cur_rc = buf_flit.head.rc;
   assign out_flit = buf_flit;

   rtr_flit_buffer u_buffer (
      .clk      (clk),
      .rst      (rst),
      .wr_valid (in_valid),
      .wr_flit  (in_flit),
      .rd_pop   (pop),
      .rd_flit  (buf_flit),
      .rd_valid (buf_valid)
   );

   rtr_route_compute_desc u_route (
      .head     (buf_flit),
      .my_x     (my_x),
      .my_y     (my_y),
      .route_op (route_op),
      .route_rc (route_rc)
   );

   rtr_route_filter_desc #(
      .port_id (port_id)
   ) u_filter (
      .route_valid  (route_valid),
      .route_in_op  (route_op),
      .route_in_rc  (route_rc),
      .cur_rc       (cur_rc),
      .route_out_op (filt_op),
      .route_out_rc (filt_rc),
      .err_port     (filt_err_port),
      .err_class    (filt_err_class)
   );

   rtr_input_ctrl u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .head_valid     (buf_valid),
      .head_kind      (head_kind),
      .filt_op        (filt_op),
      .filt_rc        (filt_rc),
      .filt_err_port  (filt_err_port),
      .filt_err_class (filt_err_class),
      .has_credit     (has_credit),
      .pop            (pop),
      .consume        (consume),
      .credit_out     (credit_out),
      .out_valid      (out_valid),
      .out_port       (out_port),
      .out_rc         (out_rc),
      .err_port       (err_port),
      .err_class      (err_class),
      .route_valid    (route_valid)
   );

   rtr_credit_counter u_credits (
      .clk           (clk),
      .rst           (rst),
      .consume       (consume),
      .credit_return (credit_in),
      .has_credit    (has_credit)
   );

endmodule

// File: hdl/rtr_input_ctrl.sv
// input port controller: per-packet route capture, then forward or discard to the tail
module rtr_input_ctrl (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       head_valid,
   input  rtr_flit_pkg::flit_kind_t   head_kind,
   input  rtr_topo_pkg::port_vec_t    filt_op,
   input  logic                       filt_rc,
   input  logic                       filt_err_port,
   input  logic                       filt_err_class,
   input  logic                       has_credit,
   output logic                       pop,
   output logic                       consume,
   output logic                       credit_out,
   output logic                       out_valid,
   output rtr_topo_pkg::port_vec_t    out_port,
   output logic                       out_rc,
   output logic                       err_port,
   output logic                       err_class,
   output logic                       route_valid
);
   import rtr_topo_pkg::*;
   import rtr_flit_pkg::*;

   logic [ctrl_state_w-1:0]  state;
   logic [ctrl_state_w-1:0]  state_next;
   logic                     is_last;
   logic                     fwd_fire;
   logic                     drop_fire;
   port_vec_t                route_op_q;
   logic                     route_rc_q;
   logic                     err_port_q;
   logic                     err_class_q;

   assign is_last = (head_kind == fk_tail) || (head_kind == fk_head_tail);
   assign route_valid = (state == ctrl_idle);

   // --------------------
   // per-cycle pop decision
   assign fwd_fire = (state == ctrl_forward) && head_valid && has_credit;
   assign drop_fire = (state == ctrl_discard) && head_valid;

   assign out_valid = fwd_fire;
   assign consume = fwd_fire;
   assign pop = fwd_fire || drop_fire;
   // every flit leaving the buffer frees one upstream credit
   assign credit_out = pop;

   assign out_port = route_op_q;
   assign out_rc = route_rc_q;
   assign err_port = err_port_q;
   assign err_class = err_class_q;

   // --------------------
   // state machine
   always_comb begin
      state_next = state;
      case (state)
         ctrl_idle: begin
            if (head_valid) begin
               state_next = ctrl_route;
            end
         end
         ctrl_route: begin
            state_next = (err_port_q || err_class_q) ? ctrl_discard : ctrl_forward;
         end
         ctrl_forward: begin
            if (fwd_fire && is_last) begin
               state_next = ctrl_idle;
            end
         end
         default: begin
            if (drop_fire && is_last) begin
               state_next = ctrl_idle;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ctrl_idle;
         err_port_q <= 1'b0;
         err_class_q <= 1'b0;
      end else begin
         state <= state_next;
         // flags only live for the ROUTE cycle
         err_port_q <= route_valid && head_valid && filt_err_port;
         err_class_q <= route_valid && head_valid && filt_err_class;
      end
   end

   // route held for the body flits of the packet
   always_ff @(posedge clk) begin
      if (route_valid && head_valid) begin
         route_op_q <= filt_op;
         route_rc_q <= filt_rc;
      end
   end

endmodule

// File: hdl/rtr_route_filter_desc.sv
// route filter for descending dimension order: masks illegal turns and classes, flags errors
module rtr_route_filter_desc #(
   parameter int port_id = 0
) (
   input  logic                     route_valid,
   input  rtr_topo_pkg::port_vec_t  route_in_op,
   input  logic                     route_in_rc,
   input  logic                     cur_rc,
   output rtr_topo_pkg::port_vec_t  route_out_op,
   output logic                     route_out_rc,
   output logic                     err_port,
   output logic                     err_class
);
   import rtr_topo_pkg::*;

   port_vec_t  blocked;
   logic       last_class;
   logic       class_ok;

   assign last_class = (int'(cur_rc) == rc_last);

   // --------------------
   // port rules
   always_comb begin
      for (int op = 0; op < num_ports; op++) begin
         if (op < num_net_ports) begin
            // in the last class no u-turn, and no step back up to a higher dimension
            blocked[op] = last_class &&
                          ((op == port_id) ||
                           ((op / num_neighbors_per_dim > port_id / num_neighbors_per_dim) &&
                            (port_id < num_net_ports)));
         end else begin
            blocked[op] = (op == port_id);
         end
      end
   end

   assign route_out_op = route_in_op & ~blocked;

   // --------------------
   // class rules
   // a hop either keeps the class or advances by one
   assign class_ok = (int'(route_in_rc) < num_resource_classes) &&
                     ((int'(route_in_rc) == int'(cur_rc)) ||
                      (int'(route_in_rc) == int'(cur_rc) + 1));

   assign route_out_rc = class_ok ? route_in_rc : cur_rc;

   // empty request counts as a port error too
   assign err_port = route_valid && ((|(route_in_op & blocked)) || !(|route_in_op));
   assign err_class = route_valid && !class_ok;

endmodule

// File: hdl/rtr_route_compute_desc.sv
// route computation for a head flit: phased dimension-order, y resolved before x
module rtr_route_compute_desc (
   input  rtr_flit_pkg::flit_t                 head,
   input  logic [rtr_topo_pkg::coord_w-1:0]    my_x,
   input  logic [rtr_topo_pkg::coord_w-1:0]    my_y,
   output rtr_topo_pkg::port_vec_t             route_op,
   output logic                                route_rc
);
   import rtr_topo_pkg::*;

   logic                at_int;
   logic                next_rc;
   logic [coord_w-1:0]  tgt_x;
   logic [coord_w-1:0]  tgt_y;

   // --------------------
   // phase handling
   // reaching the intermediate node moves a class-0 packet into class 1
   assign at_int = (head.head.int_x == my_x) && (head.head.int_y == my_y);
   assign next_rc = head.head.rc || at_int;

   assign tgt_x = next_rc ? head.head.dest_x : head.head.int_x;
   assign tgt_y = next_rc ? head.head.dest_y : head.head.int_y;

   assign route_rc = next_rc;

   // --------------------
   // output port selection
   always_comb begin
      route_op = '0;
      if (tgt_y > my_y) begin
         route_op[port_yp] = 1'b1;
      end else if (tgt_y < my_y) begin
         route_op[port_ym] = 1'b1;
      end else if (tgt_x > my_x) begin
         route_op[port_xp] = 1'b1;
      end else if (tgt_x < my_x) begin
         route_op[port_xm] = 1'b1;
      end else begin
         // target reached, eject here
         route_op[port_local] = 1'b1;
      end
   end

endmodule

// File: hdl/rtr_credit_counter.sv
// downstream credit counter: one credit per sent flit, one back per returned pulse
module rtr_credit_counter (
   input  logic  clk,
   input  logic  rst,
   input  logic  consume,
   input  logic  credit_return,
   output logic  has_credit
);
   import rtr_topo_pkg::*;

   logic [cnt_w-1:0] count;

   assign has_credit = (count != '0);

   // a consume and a return in the same cycle cancel out
   always_ff @(posedge clk) begin
      if (rst) begin
         count <= cnt_w'(out_credits);
      end else begin
         case ({consume, credit_return})
            2'b10: count <= count - 1'b1;
            2'b01: count <= count + 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: hdl/rtr_flit_buffer.sv
// input flit buffer: circular FIFO filled by the upstream router against credits
module rtr_flit_buffer (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 wr_valid,
   input  rtr_flit_pkg::flit_t  wr_flit,
   input  logic                 rd_pop,
   output rtr_flit_pkg::flit_t  rd_flit,
   output logic                 rd_valid
);
   import rtr_topo_pkg::*;
   import rtr_flit_pkg::*;

   flit_t               mem [in_buf_depth];
   logic [buf_ptr_w-1:0] wr_ptr;
   logic [buf_ptr_w-1:0] rd_ptr;
   logic [buf_ptr_w:0]   count;
   logic                 do_pop;

   // popping an empty buffer is ignored
   assign do_pop = rd_pop && rd_valid;

   assign rd_valid = (count != '0);
   assign rd_flit = mem[rd_ptr];

   // flit storage
   always_ff @(posedge clk) begin
      if (wr_valid) begin
         mem[wr_ptr] <= wr_flit;
      end
   end

   // --------------------
   // pointers and occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (wr_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (wr_valid && !do_pop) begin
            count <= count + 1'b1;
         end else if (!wr_valid && do_pop) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// File: hdl/rtr_flit_pkg.sv
// flit formats for the router: flit kinds, head and body views, packet handling states
package rtr_flit_pkg;

   // --------------------
   // flit kinds
   typedef enum logic [1:0] {
      fk_head      = 2'd0,
      fk_body      = 2'd1,
      fk_tail      = 2'd2,
      fk_head_tail = 2'd3
   } flit_kind_t;

   // --------------------
   // flit word views
   // head view carries the routing fields, 2+1+4*3+17 = 32 bits
   typedef struct packed {
      flit_kind_t                        kind;
      logic                              rc;
      logic [rtr_topo_pkg::coord_w-1:0]  dest_x;
      logic [rtr_topo_pkg::coord_w-1:0]  dest_y;
      logic [rtr_topo_pkg::coord_w-1:0]  int_x;
      logic [rtr_topo_pkg::coord_w-1:0]  int_y;
      logic [16:0]                       tag;
   } flit_head_t;

   typedef struct packed {
      flit_kind_t   kind;
      logic [29:0]  payload;
   } flit_body_t;

   // kind sits in the same two bits for both views
   typedef union packed {
      flit_head_t  head;
      flit_body_t  body;
   } flit_t;

   // --------------------
   // input controller states
   localparam int ctrl_state_w = 2;
   localparam logic [ctrl_state_w-1:0] ctrl_idle    = 2'd0;
   localparam logic [ctrl_state_w-1:0] ctrl_route   = 2'd1;
   localparam logic [ctrl_state_w-1:0] ctrl_forward = 2'd2;
   localparam logic [ctrl_state_w-1:0] ctrl_discard = 2'd3;

endpackage

// File: hdl/rtr_topo_pkg.sv
// mesh router topology: grid size, port numbering, resource classes and buffer sizing
package rtr_topo_pkg;

   // --------------------
   // mesh geometry
   localparam int coord_w = 3;
   localparam int num_ports = 5;
   localparam int num_neighbors_per_dim = 2;
   localparam int num_net_ports = 4;

   // port indices, network ports first, two per dimension
   localparam int port_xm = 0;
   localparam int port_xp = 1;
   localparam int port_ym = 2;
   localparam int port_yp = 3;
   localparam int port_local = 4;

   // --------------------
   // resource classes
   // class 0 heads for the intermediate node, class 1 for the destination
   localparam int num_resource_classes = 2;
   localparam int rc_last = 1;

   // --------------------
   // buffering and credits
   localparam int in_buf_depth = 8;
   localparam int buf_ptr_w = $clog2(in_buf_depth);
   localparam int out_credits = 4;
   localparam int cnt_w = 3;

   typedef logic [num_ports-1:0] port_vec_t;

endpackage
